// ==== list.f ====
hdl/scope_pkg.sv
hdl/stats_if.sv
hdl/frame_stats.sv
hdl/trace_buffer.sv
hdl/raster_scan.sv
hdl/pixel_render.sv
hdl/tiny_scope.sv
bench/tiny_scope_sva.sv
bench/tb_tiny_scope.sv

// ==== bench/tb_tiny_scope.sv ====
// testbench for tiny_scope on a synthetic 48 x 220 raster with 4 vsync lines
// samples come from $urandom seeded with 37, strobe at about one half
// the strobe is forced on the vsync rise that opens a period, so each lasts N_FRAMES
// in-window colours are checked once 40 columns are written, black outside always
`timescale 1ns/1ps

module tb_tiny_scope;

	localparam int H_START  = 8;
	localparam int H_END    = 39;
	localparam int V_START  = 24;
	localparam int N_FRAMES = 2;
	localparam int LINE_ACTIVE    = 48;
	localparam int LINE_BLANK     = 8;
	localparam int FRAME_LINES    = 220;
	localparam int VSYNC_LINES    = 4;
	localparam int CHECK_COLUMNS  = 40;
	localparam int COLUMN_TIMEOUT = 1_200_000;
	localparam int FRAME_TIMEOUT  = 20_000;
	localparam scope_pkg::rgb_t LANE_COL [4] = '{scope_pkg::COL_A0, scope_pkg::COL_A1,
		scope_pkg::COL_B0, scope_pkg::COL_B1};

	logic clk;
	logic reset;
	logic blank;
	logic vsync;
	logic ad_strobe;
	scope_pkg::sample_t drv [4];
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;

	// stimulus state, mode 0/2 wide, 1 quiet, 3 quiet with a single sample
	int cur_px;
	int cur_line;
	int mode;
	scope_pkg::sample_t base [4];

	// model state
	logic vs_last;
	int frame_cnt;
	int sec_cnt;
	int rise_cnt;
	int err_cnt;
	logic started;
	logic mark_m;
	scope_pkg::sample_t min_m [4];
	scope_pkg::sample_t max_m [4];
	logic [31:0] col_min_q [$];
	logic [31:0] col_max_q [$];
	logic col_mark_q [$];
	logic [24:0] exp_q [$];

	tiny_scope #(
		.H_START (H_START),
		.H_END   (H_END),
		.V_START (V_START),
		.N_FRAMES(N_FRAMES)
	) u_tiny_scope (
		.clk      (clk),
		.reset    (reset),
		.blank    (blank),
		.vsync    (vsync),
		.ad_a0    (drv[0]),
		.ad_a1    (drv[1]),
		.ad_b0    (drv[2]),
		.ad_b1    (drv[3]),
		.ad_strobe(ad_strobe),
		.red      (red),
		.green    (green),
		.blue     (blue)
	);

	bind frame_stats tiny_scope_sva u_handshake_sva (
		.clk  (clk),
		.reset(reset),
		.req  (stats.req),
		.ack  (stats.ack),
		.mins (stats.mins),
		.maxs (stats.maxs),
		.mark (stats.mark)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "stopped on first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
			abort_run("pixel colour differs from the model");
		end
	endtask

	function automatic scope_pkg::sample_t draw_sample(input int k);
		// odd modes stay in a narrow band above the period base
		if (mode % 2 == 1)
			return base[k] + scope_pkg::sample_t'($urandom % 128);
		return scope_pkg::sample_t'($urandom % 4096);
	endfunction

	task automatic drive_cycle(input logic blk, input logic vs, input int px, input int ln,
		input logic open);
		blank = blk;
		vsync = vs;
		cur_px = px;
		cur_line = ln;
		if (open)
			ad_strobe = 1'b1;
		else if (mode == 3)
			ad_strobe = 1'b0;
		else
			ad_strobe = 1'($urandom % 2);
		for (int k = 0; k < 4; k++)
			drv[k] = draw_sample(k);
		@(posedge clk);
		#1;
	endtask

	task automatic video_run();
		int f;
		f = 0;
		forever begin
			for (int ln = 0; ln < FRAME_LINES; ln++) begin
				for (int i = 0; i < LINE_ACTIVE; i++)
					drive_cycle(1'b0, 1'b0, i, ln, 1'b0);
				repeat (LINE_BLANK)
					drive_cycle(1'b1, 1'b0, -1, ln, 1'b0);
			end
			// this vsync rise opens a new period
			if (f % N_FRAMES == 0) begin
				mode = (f / N_FRAMES) % 4;
				for (int k = 0; k < 4; k++)
					base[k] = scope_pkg::sample_t'($urandom % 3968);
			end
			for (int i = 0; i < VSYNC_LINES * (LINE_ACTIVE + LINE_BLANK); i++)
				drive_cycle(1'b1, 1'b1, -1, 0, (i == 0) && (f % N_FRAMES == 0));
			f++;
		end
	endtask

	// colour of window column xr, line yr from the newest columns
	function automatic scope_pkg::rgb_t expected_colour(input int xr, input int yr);
		int idx;
		int pos;
		idx = col_mark_q.size() - 1 - (H_END - H_START - xr);
		for (int k = 0; k < 4; k++) begin
			pos = yr + scope_pkg::LANE_OFFSET[k];
			if (int'(col_min_q[idx][8*k +: 8]) <= pos && int'(col_max_q[idx][8*k +: 8]) >= pos)
				return LANE_COL[k];
		end
		if (col_mark_q[idx] || (yr % scope_pkg::GRID_PITCH) == 16)
			return scope_pkg::COL_GRID;
		return scope_pkg::COL_BG;
	endfunction

	//////////////////////////////
	// model
	//////////////////////////////
	always @(posedge clk) begin : model_step
		logic vs_rise;
		logic vs_fall;
		logic close;
		logic in_win;
		logic [31:0] lo;
		logic [31:0] hi;
		int x;
		if (reset) begin
			vs_last = 1'b0;
			frame_cnt = 0;
			sec_cnt = 0;
			started = 1'b0;
			exp_q.push_back({1'b1, scope_pkg::COL_OFF});
		end else begin
			vs_rise = vsync && !vs_last;
			vs_fall = !vsync && vs_last;
			close = ad_strobe && vs_rise && frame_cnt == 0;
			if (vs_rise)
				rise_cnt++;
			if (close) begin
				if (started) begin
					for (int k = 0; k < 4; k++) begin
						lo[8*k +: 8] = min_m[k][11:4];
						hi[8*k +: 8] = max_m[k][11:4];
					end
					col_min_q.push_back(lo);
					col_max_q.push_back(hi);
					col_mark_q.push_back(mark_m);
				end
				started = 1'b1;
				for (int k = 0; k < 4; k++) begin
					min_m[k] = drv[k];
					max_m[k] = drv[k];
				end
				mark_m = (sec_cnt == 0);
			end else if (ad_strobe) begin
				for (int k = 0; k < 4; k++) begin
					if (drv[k] < min_m[k])
						min_m[k] = drv[k];
					if (drv[k] > max_m[k])
						max_m[k] = drv[k];
				end
				mark_m = mark_m || (sec_cnt == 0);
			end
			if (vs_fall) begin
				frame_cnt = (frame_cnt + 1) % N_FRAMES;
				sec_cnt = (sec_cnt + 1) % scope_pkg::FRAMES_PER_MARK;
			end
			vs_last = vsync;
			// xcnt being registered on this edge
			x = blank ? 0 : cur_px + 1;
			in_win = !blank && !vsync && x >= H_START && x <= H_END &&
				cur_line >= V_START && cur_line < V_START + scope_pkg::V_HEIGHT;
			if (!in_win)
				exp_q.push_back({1'b1, scope_pkg::COL_OFF});
			else if (col_mark_q.size() < CHECK_COLUMNS)
				exp_q.push_back(25'h0);
			else
				exp_q.push_back({1'b1, expected_colour(x - H_START, cur_line - V_START)});
		end
	end

	// three clocks of latency, compared on the falling edge
	always @(negedge clk) begin : output_check
		logic [24:0] e;
		if (exp_q.size() >= 4) begin
			e = exp_q.pop_front();
			if (e[24]) begin
				compare_value("red", red, e[23:16]);
				compare_value("green", green, e[15:8]);
				compare_value("blue", blue, e[7:0]);
			end
		end
	end

	// handshake assertions in the bound checker
	always @(negedge clk) begin
		if (u_tiny_scope.u_frame_stats.u_handshake_sva.fail_cnt != 0)
			abort_run("handshake assertion failed in frame_stats");
	end

	task automatic wait_columns(input int n);
		int cycles;
		cycles = 0;
		while (col_mark_q.size() < n) begin
			@(negedge clk);
			cycles++;
			if (cycles > COLUMN_TIMEOUT)
				abort_run("timeout waiting for trace columns to be written");
		end
	endtask

	task automatic wait_frame();
		int start;
		int cycles;
		start = rise_cnt;
		cycles = 0;
		while (rise_cnt == start) begin
			@(negedge clk);
			cycles++;
			if (cycles > FRAME_TIMEOUT)
				abort_run("timeout waiting for a vsync rise");
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		int seed_draw;
		reset = 1'b1;
		blank = 1'b1;
		vsync = 1'b1;
		ad_strobe = 1'b0;
		for (int k = 0; k < 4; k++) begin
			drv[k] = '0;
			base[k] = '0;
		end
		mode = 0;
		cur_px = -1;
		cur_line = 0;
		rise_cnt = 0;
		err_cnt = 0;
		seed_draw = $urandom(37);
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		fork
			video_run();
		join_none
		wait_columns(CHECK_COLUMNS);
		repeat (6) wait_frame();
		if (err_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== bench/tiny_scope_sva.sv ====
// request side checks for the stats_if handshake, bound into frame_stats
// data is only checked for holding once the first req has been raised
`timescale 1ns/1ps

module tiny_scope_sva (
	input logic clk,
	input logic reset,
	input logic req,
	input logic ack,
	input scope_pkg::chan_levels_t mins,
	input scope_pkg::chan_levels_t maxs,
	input logic mark
);

	// count of failed assertions
	int fail_cnt = 0;

	// req may only fall once ack is up
	req_until_ack: assert property (@(posedge clk) disable iff (reset) req && !ack |=> req)
		else begin
			fail_cnt++;
			$error("req dropped before ack rose");
		end

	// ack stays up until req has fallen
	ack_after_req: assert property (@(posedge clk) disable iff (reset) req && ack |=> ack)
		else begin
			fail_cnt++;
			$error("ack dropped while req still high");
		end

	data_hold: assert property (@(posedge clk) disable iff (reset)
		(req || ack) |=> $stable({mins, maxs, mark}))
		else begin
			fail_cnt++;
			$error("period data changed during handshake");
		end

	req_reset: assert property (@(posedge clk) reset |=> !req)
		else begin
			fail_cnt++;
			$error("req high after reset");
		end

endmodule

// ==== hdl/tiny_scope.sv ====
// scrolling min/max scope drawn inside a window, one column per N_FRAMES frames
// samples are taken on clk when ad_strobe is set
// colour for pixel x appears 3 clocks after the edge that registers xcnt = x
// window width H_END - H_START + 1 must not exceed 512 columns
`timescale 1ns/1ps

module tiny_scope #(
	parameter int H_START  = 8,
	parameter int H_END    = 39,
	parameter int V_START  = 24,
	parameter int N_FRAMES = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic blank,
	input  logic vsync,
	input  scope_pkg::sample_t ad_a0,
	input  scope_pkg::sample_t ad_a1,
	input  scope_pkg::sample_t ad_b0,
	input  scope_pkg::sample_t ad_b1,
	input  logic ad_strobe,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	scope_pkg::coord_t x_rel;
	scope_pkg::coord_t y_rel;
	logic in_window;
	scope_pkg::chan_levels_t col_mins;
	scope_pkg::chan_levels_t col_maxs;
	logic col_mark;
	scope_pkg::rgb_t rgb;

	stats_if u_stats ();

	// samples[0] is a0
	frame_stats #(
		.N_FRAMES(N_FRAMES)
	) u_frame_stats (
		.clk      (clk),
		.reset    (reset),
		.vsync    (vsync),
		.ad_strobe(ad_strobe),
		.samples  ({ad_b1, ad_b0, ad_a1, ad_a0}),
		.stats    (u_stats.source)
	);

	trace_buffer #(
		.H_START(H_START),
		.H_END  (H_END)
	) u_trace_buffer (
		.clk     (clk),
		.reset   (reset),
		.stats   (u_stats.sink),
		.x_rel   (x_rel),
		.col_mins(col_mins),
		.col_maxs(col_maxs),
		.col_mark(col_mark)
	);

	raster_scan #(
		.H_START(H_START),
		.H_END  (H_END),
		.V_START(V_START)
	) u_raster_scan (
		.clk      (clk),
		.reset    (reset),
		.blank    (blank),
		.vsync    (vsync),
		.x_rel    (x_rel),
		.y_rel    (y_rel),
		.in_window(in_window)
	);

	pixel_render u_pixel_render (
		.clk      (clk),
		.reset    (reset),
		.y_rel    (y_rel),
		.in_window(in_window),
		.col_mins (col_mins),
		.col_maxs (col_maxs),
		.col_mark (col_mark),
		.rgb      (rgb)
	);

	assign {red, green, blue} = rgb;

endmodule

// ==== hdl/pixel_render.sv ====
// bar, grid and background decision, colour registered
// y_rel and in_window are delayed one clock to meet the buffer read data
// priority a0, a1, b0, b1, grid, background
`timescale 1ns/1ps

module pixel_render (
	input  logic clk,
	input  logic reset,
	input  scope_pkg::coord_t y_rel,
	input  logic in_window,
	input  scope_pkg::chan_levels_t col_mins,
	input  scope_pkg::chan_levels_t col_maxs,
	input  logic col_mark,
	output scope_pkg::rgb_t rgb
);

	scope_pkg::coord_t y_d;
	logic win_d;
	logic grid;
	logic [scope_pkg::NUM_CHAN-1:0] lit;
	scope_pkg::rgb_t rgb_next;

	// line up with the read data
	always_ff @(posedge clk) begin
		y_d <= y_rel;
	end

	//////////////////////////////
	// per-channel bars
	//////////////////////////////
	always_comb begin
		for (int k = 0; k < scope_pkg::NUM_CHAN; k++) begin
			int pos;
			pos = int'(y_d) + scope_pkg::LANE_OFFSET[k];
			lit[k] = (int'(scope_pkg::lane_level(col_mins, k)) <= pos) &&
				(int'(scope_pkg::lane_level(col_maxs, k)) >= pos);
		end
	end

	// vertical line on marked columns, horizontal every GRID_PITCH lines
	assign grid = col_mark | ((y_d % scope_pkg::GRID_PITCH) == scope_pkg::GRID_PHASE);

	always_comb begin
		if (!win_d)
			rgb_next = scope_pkg::COL_OFF;
		else if (lit[0])
			rgb_next = scope_pkg::COL_A0;
		else if (lit[1])
			rgb_next = scope_pkg::COL_A1;
		else if (lit[2])
			rgb_next = scope_pkg::COL_B0;
		else if (lit[3])
			rgb_next = scope_pkg::COL_B1;
		else if (grid)
			rgb_next = scope_pkg::COL_GRID;
		else
			rgb_next = scope_pkg::COL_BG;
	end

	//////////////////////////////
	// output register
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			win_d <= 1'b0;
			rgb   <= scope_pkg::COL_OFF;
		end else begin
			win_d <= in_window;
			rgb   <= rgb_next;
		end
	end

endmodule

// ==== hdl/raster_scan.sv ====
// pixel and line counters from blank and vsync
// x_rel, y_rel and in_window are registered one clock after xcnt/ycnt
// offsets wrap outside the window, only meaningful with in_window set
`timescale 1ns/1ps

module raster_scan #(
	parameter int H_START = 8,
	parameter int H_END   = 39,
	parameter int V_START = 24
) (
	input  logic clk,
	input  logic reset,
	input  logic blank,
	input  logic vsync,
	output scope_pkg::coord_t x_rel,
	output scope_pkg::coord_t y_rel,
	output logic in_window
);

	logic blank_d1;
	scope_pkg::coord_t xcnt;
	scope_pkg::coord_t ycnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			blank_d1  <= 1'b0;
			xcnt      <= '0;
			ycnt      <= '0;
			in_window <= 1'b0;
		end else begin
			blank_d1 <= blank;
			xcnt     <= blank ? '0 : xcnt + 1'b1;
			// one line per rise of blank
			if (vsync)
				ycnt <= '0;
			else if (blank & ~blank_d1)
				ycnt <= ycnt + 1'b1;
			in_window <= (xcnt >= H_START) && (xcnt <= H_END) &&
				(ycnt >= V_START) && (ycnt < V_START + scope_pkg::V_HEIGHT);
		end
	end

	always_ff @(posedge clk) begin
		x_rel <= xcnt - scope_pkg::coord_t'(H_START);
		y_rel <= ycnt - scope_pkg::coord_t'(V_START);
	end

endmodule

// ==== hdl/trace_buffer.sv ====
// circular column store, 512 entries of {maxs, mins, mark}
// sink side of the four-phase handshake, ack simply follows req
// read is one clock, addressed so that x_rel = H_END - H_START is the newest column
// memory has no reset, columns never written read back as X
`timescale 1ns/1ps

module trace_buffer #(
	parameter int H_START = 8,
	parameter int H_END   = 39
) (
	input  logic clk,
	input  logic reset,
	stats_if.sink stats,
	input  scope_pkg::coord_t x_rel,
	output scope_pkg::chan_levels_t col_mins,
	output scope_pkg::chan_levels_t col_maxs,
	output logic col_mark
);

	localparam int DEPTH = 2 ** $bits(scope_pkg::col_addr_t);
	localparam int CW    = $bits(scope_pkg::chan_levels_t);
	localparam scope_pkg::col_addr_t SPAN = scope_pkg::col_addr_t'(H_END - H_START);

	logic [2*CW:0] mem [DEPTH];
	logic [2*CW:0] rd_word;
	scope_pkg::col_addr_t wr_ptr;
	scope_pkg::col_addr_t rd_addr;
	logic wr_en;

	// one write per handshake, on the first clock req is seen
	assign wr_en = stats.req & ~stats.ack;

	// wr_ptr already points past the newest column
	assign rd_addr = wr_ptr - SPAN - 1'b1 + scope_pkg::col_addr_t'(x_rel);

	always_ff @(posedge clk) begin
		if (reset) begin
			stats.ack <= 1'b0;
			wr_ptr    <= SPAN;
		end else begin
			stats.ack <= stats.req;
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	//////////////////////////////
	// column memory
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= {stats.maxs, stats.mins, stats.mark};
		rd_word <= mem[rd_addr];
	end

	assign {col_maxs, col_mins, col_mark} = rd_word;

endmodule

// ==== hdl/frame_stats.sv ====
// min/max capture of four channels over N_FRAMES video frames
// a period closes on a strobed clock at a vsync rise when frame_cnt is zero
// the first close after reset only opens a period, no req is raised
// next close must be at least four clocks after req rises
`timescale 1ns/1ps

module frame_stats #(
	parameter int N_FRAMES = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic vsync,
	input  logic ad_strobe,
	input  scope_pkg::sample_t [scope_pkg::NUM_CHAN-1:0] samples,
	stats_if.source stats
);

	localparam int FW = $clog2(N_FRAMES + 1);
	localparam int SW = $clog2(scope_pkg::FRAMES_PER_MARK);
	localparam int SB = $bits(scope_pkg::sample_t);
	localparam int LB = $bits(scope_pkg::level_t);

	logic vsync_d1;
	logic vs_rise;
	logic vs_fall;
	logic close;
	logic started;
	logic req_go;
	logic mark_cur;
	logic [FW-1:0] frame_cnt;
	logic [SW-1:0] sec_cnt;
	scope_pkg::sample_t min_cur [scope_pkg::NUM_CHAN];
	scope_pkg::sample_t max_cur [scope_pkg::NUM_CHAN];

	assign vs_rise = vsync & ~vsync_d1;
	assign vs_fall = ~vsync & vsync_d1;
	assign close   = ad_strobe & vs_rise & (frame_cnt == '0);

	//////////////////////////////
	// frame / second counters and req side
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_d1  <= 1'b0;
			frame_cnt <= '0;
			sec_cnt   <= '0;
			started   <= 1'b0;
			req_go    <= 1'b0;
			stats.req <= 1'b0;
		end else begin
			vsync_d1 <= vsync;
			if (vs_fall) begin
				frame_cnt <= (frame_cnt == FW'(N_FRAMES - 1)) ? '0 : frame_cnt + 1'b1;
				sec_cnt   <= (sec_cnt == SW'(scope_pkg::FRAMES_PER_MARK - 1)) ?
					'0 : sec_cnt + 1'b1;
			end
			if (close)
				started <= 1'b1;
			// held data loads on the close edge, req follows one clock later
			req_go <= close & started;
			if (req_go)
				stats.req <= 1'b1;
			else if (stats.ack)
				stats.req <= 1'b0;
		end
	end

	//////////////////////////////
	// running extremes
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (ad_strobe) begin
			if (close) begin
				// this sample opens the next period
				for (int k = 0; k < scope_pkg::NUM_CHAN; k++) begin
					min_cur[k] <= samples[k];
					max_cur[k] <= samples[k];
					stats.mins[LB * (scope_pkg::NUM_CHAN - 1 - k) +: LB] <=
						min_cur[k][SB-1 -: LB];
					stats.maxs[LB * (scope_pkg::NUM_CHAN - 1 - k) +: LB] <=
						max_cur[k][SB-1 -: LB];
				end
				mark_cur   <= (sec_cnt == '0);
				stats.mark <= mark_cur;
			end else begin
				for (int k = 0; k < scope_pkg::NUM_CHAN; k++) begin
					if (samples[k] < min_cur[k])
						min_cur[k] <= samples[k];
					if (samples[k] > max_cur[k])
						max_cur[k] <= samples[k];
				end
				// sticky, any second tick inside the period marks it
				mark_cur <= mark_cur | (sec_cnt == '0);
			end
		end
	end

endmodule

// ==== hdl/stats_if.sv ====
// one closed capture period on its way into the trace buffer
// four-phase req/ack, data must hold while req or ack is high
`timescale 1ns/1ps

interface stats_if;

	scope_pkg::chan_levels_t mins;
	scope_pkg::chan_levels_t maxs;
	logic mark;
	logic req;
	logic ack;

	modport source (
		output mins,
		output maxs,
		output mark,
		output req,
		input  ack
	);

	modport sink (
		input  mins,
		input  maxs,
		input  mark,
		input  req,
		output ack
	);

endinterface

// ==== hdl/scope_pkg.sv ====
// shared widths, colours and display constants for the scrolling scope
// channel order everywhere is a0, a1, b0, b1
// chan_levels_t packs a0 in the top byte and b1 in the bottom byte
package scope_pkg;

	typedef logic [11:0] sample_t;
	typedef logic [7:0]  level_t;
	typedef logic [31:0] chan_levels_t;
	typedef logic [9:0]  coord_t;
	typedef logic [8:0]  col_addr_t;
	typedef logic [23:0] rgb_t;

	localparam int NUM_CHAN = 4;

	// window height and grid spacing, in lines
	localparam int V_HEIGHT    = 192;
	localparam int GRID_PITCH  = 32;
	localparam int GRID_PHASE  = 16;

	// lane shift added to the line offset before comparing with a level
	localparam int LANE_OFFSET [NUM_CHAN] = '{48, 16, -16, -48};

	// vsync falls per one second mark
	localparam int FRAMES_PER_MARK = 60;

	//////////////////////////////
	// colours
	//////////////////////////////
	localparam rgb_t COL_A0   = 24'hffffff;
	localparam rgb_t COL_A1   = 24'hff0000;
	localparam rgb_t COL_B0   = 24'h00ff00;
	localparam rgb_t COL_B1   = 24'h0000ff;
	localparam rgb_t COL_GRID = 24'h32006a;
	localparam rgb_t COL_BG   = 24'h1d1d1d;
	localparam rgb_t COL_OFF  = 24'h000000;

	// level of channel k (0 = a0) from a packed set of four
	function automatic level_t lane_level(chan_levels_t levels, int k);
		return levels[$bits(level_t) * (NUM_CHAN - 1 - k) +: $bits(level_t)];
	endfunction

endpackage
